/* include/lsu_consts.svh */
// Load path constants
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ------------------------------
// Memory geometry
// ------------------------------

// Number of 32-bit words in the data memory, which gives an 8-bit byte address
`define LSU_MEM_WORDS 64

// Number of pending stores the buffer can hold
`define LSU_SB_DEPTH 4

// ------------------------------
// Protection and timing
// ------------------------------

// First and last byte address of the machine-only region
`define LSU_PRIV_START 8'hC0
`define LSU_PRIV_END 8'hFF

// Cycles from an accepted read request to its valid strobe
`define LSU_MEM_LATENCY 2

`endif

/* hdl/lsu_pkg.sv */
// Load path types
package lsu_pkg;

    // ------------------------------
    // Data word
    // ------------------------------

    // One memory word, seen either whole, as two halves or as four bytes
    // Index 0 is always the least significant lane
    typedef union packed {
        logic [31:0]      word32;
        logic [1:0][15:0] word16;
        logic [3:0][7:0]  word8;
    } data_word_t;

    // ------------------------------
    // Load operation
    // ------------------------------

    // Access width of a load
    typedef enum logic [1:0] {
        LDB,
        LDH,
        LDW
    } ldu_width_t;

    // Micro-op handed to the load unit by the decoder
    // signed_load selects sign extension for byte and halfword loads
    typedef struct packed {
        ldu_width_t width;
        logic       signed_load;
    } ldu_uop_t;

    // ------------------------------
    // Stores
    // ------------------------------

    // One pending store, always a full word
    // The two low address bits are carried but ignored by the memory
    typedef struct packed {
        logic [7:0] address;
        data_word_t data;
    } store_entry_t;

    // ------------------------------
    // Load channel
    // ------------------------------

    // Request from the load unit, high for a single cycle per load
    typedef struct packed {
        logic       request;
        logic [7:0] address;
    } load_req_t;

    // Response from the memory, valid for a single cycle
    typedef struct packed {
        logic       valid;
        data_word_t data;
    } load_rsp_t;

endpackage : lsu_pkg

/* hdl/load_unit.sv */
// Load unit
`timescale 1ns/1ps
`include "lsu_consts.svh"

module load_unit import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  logic       privilege_i,
    input  logic       valid_operation_i,
    input  logic [7:0] load_address_i,
    input  ldu_uop_t   operation_i,
    output load_req_t  load_req_o,
    input  load_rsp_t  load_rsp_i,
    input  logic       forward_match_i,
    input  data_word_t forward_data_i,
    input  logic       buffer_wait_i,
    output data_word_t data_loaded_o,
    output logic       illegal_access_o,
    output logic       misaligned_o,
    output logic       idle_o,
    output logic       data_valid_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MEMORY_UPDATE,
        WAIT_MEMORY,
        WAIT_STALL
    } state_t;

    state_t     state_q, state_d;
    ldu_uop_t   operation_q;
    logic [7:0] address_q;
    logic       accept;
    logic       misaligned;
    logic       private_region;
    data_word_t data_selected;
    data_word_t data_sliced;
    logic       capture;
    data_word_t result_q;

    // ------------------------------
    // Exception checks
    // ------------------------------

    // A new load is only taken while the unit sits in IDLE
    assign accept = valid_operation_i & (state_q == IDLE);

    // Halfwords need an even address and words a multiple of four
    always_comb begin
        case (operation_i.width)
            LDH:     misaligned = load_address_i[0];
            LDW:     misaligned = (load_address_i[1:0] != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    // The top of the address space is reserved for machine mode
    assign private_region = (load_address_i >= `LSU_PRIV_START) &&
                            (load_address_i <= `LSU_PRIV_END);

    assign misaligned_o     = accept & misaligned;
    assign illegal_access_o = accept & private_region & ~privilege_i;

    // Keep the operation so slicing still knows it after the inputs move on
    always_ff @(posedge clk_i) begin
        if (accept) begin
            operation_q <= operation_i;
            address_q   <= load_address_i;
        end
    end

    // ------------------------------
    // FSM
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d            = state_q;
        load_req_o.request = 1'b0;
        load_req_o.address = address_q;
        data_selected      = load_rsp_i.data;
        capture            = 1'b0;
        data_valid_o       = 1'b0;

        case (state_q)
            IDLE: begin
                // The store buffer looks up the incoming address straight away
                load_req_o.address = load_address_i;
                if (accept) begin
                    if (misaligned_o | illegal_access_o) begin
                        // Faulting loads finish at once and never reach memory
                        data_valid_o = 1'b1;
                    end else if (buffer_wait_i) begin
                        state_d = WAIT_MEMORY_UPDATE;
                    end else begin
                        load_req_o.request = 1'b1;
                        state_d            = WAIT_MEMORY;
                    end
                end
            end

            WAIT_MEMORY_UPDATE: begin
                // Hold off until the drain write has left the memory
                if (!buffer_wait_i) begin
                    load_req_o.request = 1'b1;
                    state_d            = WAIT_MEMORY;
                end
            end

            WAIT_MEMORY: begin
                // A buffered store is newer than anything in memory, so it wins
                if (forward_match_i) begin
                    data_selected = forward_data_i;
                    capture       = 1'b1;
                    state_d       = WAIT_STALL;
                end else if (load_rsp_i.valid) begin
                    capture = 1'b1;
                    state_d = WAIT_STALL;
                end
            end

            WAIT_STALL: begin
                if (!stall_i) begin
                    data_valid_o = 1'b1;
                    state_d      = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    assign idle_o = (state_q == IDLE);

    // ------------------------------
    // Slicing and result hold
    // ------------------------------

    // Pick the lane by the low address bits, then extend to a full word
    always_comb begin
        case (operation_q.width)
            LDB: begin
                data_sliced.word32 = {24'b0, data_selected.word8[address_q[1:0]]};
                if (operation_q.signed_load) begin
                    data_sliced.word32[31:8] = {24{data_selected.word8[address_q[1:0]][7]}};
                end
            end
            LDH: begin
                data_sliced.word32 = {16'b0, data_selected.word16[address_q[1]]};
                if (operation_q.signed_load) begin
                    data_sliced.word32[31:16] = {16{data_selected.word16[address_q[1]][15]}};
                end
            end
            default: data_sliced = data_selected;
        endcase
    end

    // Result stays put through any stall until data_valid_o is given
    always_ff @(posedge clk_i) begin
        if (capture) begin
            result_q <= data_sliced;
        end
    end

    // Faulting loads report zero data
    assign data_loaded_o = (misaligned_o | illegal_access_o) ? '0 : result_q;

endmodule : load_unit

/* hdl/store_buffer.sv */
// Store buffer
`timescale 1ns/1ps
`include "lsu_consts.svh"

module store_buffer import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         store_valid_i,
    input  store_entry_t store_entry_i,
    output logic         store_full_o,
    input  logic [7:0]   lookup_address_i,
    output logic         forward_match_o,
    output data_word_t   forward_data_o,
    output logic         write_en_o,
    output store_entry_t write_entry_o,
    input  logic         write_busy_i,
    output logic         buffer_wait_o
);

    localparam int PTR_W = $clog2(`LSU_SB_DEPTH);
    localparam int CNT_W = $clog2(`LSU_SB_DEPTH + 1);

    store_entry_t     entries_q [`LSU_SB_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;
    logic             write_en_q;
    logic [PTR_W-1:0] scan_idx;

    // ------------------------------
    // FIFO control
    // ------------------------------

    assign store_full_o = (count_q == CNT_W'(`LSU_SB_DEPTH));
    assign push         = store_valid_i & ~store_full_o;

    // The memory only goes busy after it took our write, so a busy flag
    // right after a request means the oldest entry is now in memory
    assign pop = write_en_q & write_busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            write_en_q <= 1'b0;
        end else begin
            write_en_q <= write_en_o;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // A new store lands at the write pointer
    always_ff @(posedge clk_i) begin
        if (push) begin
            entries_q[wr_ptr_q] <= store_entry_i;
        end
    end

    // ------------------------------
    // Drain
    // ------------------------------

    // Offer the oldest entry whenever the memory is free
    // A rejected offer simply repeats on the next cycle
    assign write_en_o    = (count_q != '0) & ~write_busy_i;
    assign write_entry_o = entries_q[rd_ptr_q];

    // Loads must not read memory while our write is still settling
    assign buffer_wait_o = write_busy_i;

    // ------------------------------
    // Forwarding
    // ------------------------------

    // Walk from oldest to youngest so the youngest match is left standing
    always_comb begin
        forward_match_o = 1'b0;
        forward_data_o  = '0;
        scan_idx        = rd_ptr_q;
        for (int i = 0; i < `LSU_SB_DEPTH; i++) begin
            scan_idx = rd_ptr_q + PTR_W'(i);
            if ((i < int'(count_q)) &&
                (entries_q[scan_idx].address[7:2] == lookup_address_i[7:2])) begin
                forward_match_o = 1'b1;
                forward_data_o  = entries_q[scan_idx].data;
            end
        end
    end

endmodule : store_buffer

/* hdl/data_memory.sv */
// Data memory
`timescale 1ns/1ps
`include "lsu_consts.svh"

module data_memory import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  load_req_t    load_req_i,
    output load_rsp_t    load_rsp_o,
    input  logic         write_en_i,
    input  store_entry_t write_entry_i,
    output logic         write_busy_o
);

    localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);
    localparam int LAT    = `LSU_MEM_LATENCY;
    localparam int BUSY_W = $clog2(LAT + 1);

    data_word_t        mem_q [`LSU_MEM_WORDS];
    logic [LAT-1:0]    valid_pipe_q;
    data_word_t        data_pipe_q [LAT];
    logic [BUSY_W-1:0] busy_cnt_q;
    logic              write_accept;
    logic [IDX_W-1:0]  read_idx;
    logic [IDX_W-1:0]  write_idx;

    // Both ports address whole words, the byte offset is dropped
    assign read_idx  = load_req_i.address[IDX_W+1:2];
    assign write_idx = write_entry_i.address[IDX_W+1:2];

    // ------------------------------
    // Write port
    // ------------------------------

    // A write needs the memory idle, and a load in the same cycle wins
    assign write_accept = write_en_i & (busy_cnt_q == '0) & ~load_req_i.request;

    always_ff @(posedge clk_i) begin
        if (write_accept) begin
            mem_q[write_idx] <= write_entry_i.data;
        end
    end

    // Busy covers the cycles after an accepted write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_cnt_q <= '0;
        end else if (write_accept) begin
            busy_cnt_q <= BUSY_W'(LAT);
        end else if (busy_cnt_q != '0) begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
        end
    end

    assign write_busy_o = (busy_cnt_q != '0);

    // ------------------------------
    // Read port
    // ------------------------------

    // The array is read in the request cycle, then the word rides
    // a shift pipeline so valid lands exactly LAT cycles later
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_pipe_q <= '0;
        end else begin
            valid_pipe_q[0] <= load_req_i.request;
            for (int s = 1; s < LAT; s++) begin
                valid_pipe_q[s] <= valid_pipe_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_req_i.request) begin
            data_pipe_q[0] <= mem_q[read_idx];
        end
        for (int s = 1; s < LAT; s++) begin
            data_pipe_q[s] <= data_pipe_q[s-1];
        end
    end

    always_comb begin
        load_rsp_o.valid = valid_pipe_q[LAT-1];
        load_rsp_o.data  = data_pipe_q[LAT-1];
    end

endmodule : data_memory

/* hdl/load_subsystem.sv */
// Load subsystem top
`timescale 1ns/1ps

module load_subsystem import lsu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         stall_i,
    input  logic         privilege_i,
    input  logic         load_valid_i,
    input  logic [7:0]   load_address_i,
    input  ldu_uop_t     load_op_i,
    input  logic         store_valid_i,
    input  store_entry_t store_entry_i,
    output logic         store_full_o,
    output data_word_t   data_loaded_o,
    output logic         data_valid_o,
    output logic         illegal_access_o,
    output logic         misaligned_o,
    output logic         idle_o
);

    // Load channel between the unit and memory
    load_req_t    load_req;
    load_rsp_t    load_rsp;

    // Forwarding and drain status from the store buffer
    logic         forward_match;
    data_word_t   forward_data;
    logic         buffer_wait;

    // Drain port into memory
    logic         write_en;
    store_entry_t write_entry;
    logic         write_busy;

    // ------------------------------
    // Load unit
    // ------------------------------

    load_unit i_load_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .privilege_i       (privilege_i),
        .valid_operation_i (load_valid_i),
        .load_address_i    (load_address_i),
        .operation_i       (load_op_i),
        .load_req_o        (load_req),
        .load_rsp_i        (load_rsp),
        .forward_match_i   (forward_match),
        .forward_data_i    (forward_data),
        .buffer_wait_i     (buffer_wait),
        .data_loaded_o     (data_loaded_o),
        .illegal_access_o  (illegal_access_o),
        .misaligned_o      (misaligned_o),
        .idle_o            (idle_o),
        .data_valid_o      (data_valid_o)
    );

    // ------------------------------
    // Store buffer
    // ------------------------------

    // The buffer snoops the address the unit is putting on the load channel
    store_buffer i_store_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .store_valid_i    (store_valid_i),
        .store_entry_i    (store_entry_i),
        .store_full_o     (store_full_o),
        .lookup_address_i (load_req.address),
        .forward_match_o  (forward_match),
        .forward_data_o   (forward_data),
        .write_en_o       (write_en),
        .write_entry_o    (write_entry),
        .write_busy_i     (write_busy),
        .buffer_wait_o    (buffer_wait)
    );

    // ------------------------------
    // Data memory
    // ------------------------------

    data_memory i_data_memory (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .load_req_i    (load_req),
        .load_rsp_o    (load_rsp),
        .write_en_i    (write_en),
        .write_entry_i (write_entry),
        .write_busy_o  (write_busy)
    );

endmodule : load_subsystem

/* bench/load_subsystem_tb.sv */
// Load subsystem testbench
`timescale 1ns/1ps
`include "lsu_consts.svh"

module load_subsystem_tb import lsu_pkg::*; ();

    // Operation counts per phase whose sum sets the timeout
    localparam int N_FILL   = `LSU_MEM_WORDS;
    localparam int N_SLICE  = 64;
    localparam int N_EXC    = 36;
    localparam int N_BURST  = 16;
    localparam int N_STALL  = 32;
    localparam int N_MIXED  = 200;
    localparam int OP_COUNT = 2 * N_FILL + N_SLICE + N_EXC + 5 * N_BURST + N_STALL + N_MIXED;
    localparam int TIMEOUT_CYCLES  = 40 * OP_COUNT;
    localparam int LOAD_WAIT_LIMIT = 32;

    logic         clk_i;
    logic         rst_n_i;
    logic         stall_i;
    logic         privilege_i;
    logic         load_valid_i;
    logic [7:0]   load_address_i;
    ldu_uop_t     load_op_i;
    logic         store_valid_i;
    store_entry_t store_entry_i;
    logic         store_full_o;
    data_word_t   data_loaded_o;
    logic         data_valid_o;
    logic         illegal_access_o;
    logic         misaligned_o;
    logic         idle_o;

    // Reference memory with the latest word stored at each index
    logic [31:0] model_mem [`LSU_MEM_WORDS];
    logic [31:0] seed = 32'hde6c079d;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    load_subsystem i_load_subsystem (.*);

    // ------------------------------
    // Clock and timeout
    // ------------------------------

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Random numbers and reference rules
    // ------------------------------

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // The upper LCG bits are used since the low ones repeat quickly
    function automatic int unsigned random_below(int unsigned n);
        return (next_random() >> 16) % n;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Shift the wanted lane down to bit 0, mask it, then extend its top bit if signed
    function automatic logic [31:0] expected_load(logic [31:0] word, logic [7:0] address,
                                                  ldu_uop_t op);
        logic [31:0] lane;
        case (op.width)
            LDB: begin
                lane = (word >> {address[1:0], 3'b000}) & 32'h0000_00ff;
                if (op.signed_load && lane[7]) begin
                    lane = lane | 32'hffff_ff00;
                end
            end
            LDH: begin
                lane = (word >> {address[1], 4'b0000}) & 32'h0000_ffff;
                if (op.signed_load && lane[15]) begin
                    lane = lane | 32'hffff_0000;
                end
            end
            default: lane = word;
        endcase
        return lane;
    endfunction

    // ------------------------------
    // Checks and bus tasks
    // ------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [7:0] address);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s at address %h: got %h expected %h", name, address, got, exp);
        end
    endtask

    // Holds store_valid_i until the buffer has room and updates the model once it is taken
    task automatic store_word(input logic [7:0] address, input logic [31:0] data);
        logic accepted;
        accepted                  = 1'b0;
        store_valid_i             = 1'b1;
        store_entry_i.address     = address;
        store_entry_i.data.word32 = data;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = !store_full_o;
            @(posedge clk_i);
            #2;
        end
        store_valid_i = 1'b0;
        model_mem[address[7:2]] = data;
    endtask

    task automatic run_load(input logic [7:0] address, input ldu_uop_t op, input logic priv,
                            input int stall_cycles);
        logic        exp_mis;
        logic        exp_ill;
        logic [31:0] exp_data;
        logic        got;
        int          waited;
        int          stall_left;
        exp_mis  = ((op.width == LDH) && address[0]) ||
                   ((op.width == LDW) && (address[1:0] != 2'b00));
        exp_ill  = (address >= `LSU_PRIV_START) && (address <= `LSU_PRIV_END) && !priv;
        exp_data = expected_load(model_mem[address[7:2]], address, op);
        load_valid_i   = 1'b1;
        load_address_i = address;
        load_op_i      = op;
        privilege_i    = priv;
        @(negedge clk_i);
        check_value("misaligned_o", 32'(misaligned_o), 32'(exp_mis), address);
        check_value("illegal_access_o", 32'(illegal_access_o), 32'(exp_ill), address);
        check_value("idle_o", 32'(idle_o), 32'h1, address);
        // A faulting load completes in its own cycle with zero data
        if (exp_mis || exp_ill) begin
            check_value("data_valid_o", 32'(data_valid_o), 32'h1, address);
            check_value("data_loaded_o", data_loaded_o.word32, 32'h0, address);
        end else begin
            check_value("data_valid_o", 32'(data_valid_o), 32'h0, address);
        end
        @(posedge clk_i);
        #2;
        load_valid_i = 1'b0;
        if (!(exp_mis || exp_ill)) begin
            stall_left = stall_cycles;
            stall_i    = (stall_left > 0);
            got        = 1'b0;
            waited     = 0;
            while (!got && waited < LOAD_WAIT_LIMIT) begin
                @(negedge clk_i);
                // The unit is busy from the cycle after acceptance until it hands over data
                check_value("idle_o", 32'(idle_o), 32'h0, address);
                if (data_valid_o) begin
                    got = 1'b1;
                    if (stall_i) begin
                        error_count++;
                        $display("data_valid_o rose while stall_i was high, address %h", address);
                    end
                    check_value("data_loaded_o", data_loaded_o.word32, exp_data, address);
                end
                @(posedge clk_i);
                #2;
                if (stall_left > 0) begin
                    stall_left--;
                end
                stall_i = (stall_left > 0);
                waited++;
            end
            stall_i = 1'b0;
            if (!got) begin
                error_count++;
                $display("Load at address %h never raised data_valid_o", address);
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        logic [7:0] address;
        ldu_uop_t   op;
        int         burst_len;
        rst_n_i        = 1'b0;
        stall_i        = 1'b0;
        privilege_i    = 1'b0;
        load_valid_i   = 1'b0;
        load_address_i = '0;
        load_op_i      = '0;
        store_valid_i  = 1'b0;
        store_entry_i  = '0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("idle_o", 32'(idle_o), 32'h1, 8'h00);
        check_value("data_valid_o", 32'(data_valid_o), 32'h0, 8'h00);
        check_value("store_full_o", 32'(store_full_o), 32'h0, 8'h00);
        @(posedge clk_i);
        #2;

        // Fill every word, then read each one back whole
        for (int i = 0; i < N_FILL; i++) begin
            store_word(8'(i * 4), random_word());
        end
        op.width       = LDW;
        op.signed_load = 1'b0;
        for (int i = 0; i < N_FILL; i++) begin
            run_load(8'(i * 4), op, 1'b1, 0);
        end

        // Byte and halfword slicing with both extensions
        for (int i = 0; i < N_SLICE; i++) begin
            op.width       = (random_below(2) == 1) ? LDH : LDB;
            op.signed_load = (random_below(2) == 1);
            address        = 8'(random_below(256));
            if (op.width == LDH) begin
                address[0] = 1'b0;
            end
            run_load(address, op, 1'b1, 0);
        end

        // Misaligned halfwords and words, then private loads without privilege
        for (int i = 0; i < N_EXC; i++) begin
            op.signed_load = (random_below(2) == 1);
            if (i % 3 == 2) begin
                op.width = ldu_width_t'(2'(random_below(3)));
                address  = 8'(`LSU_PRIV_START + random_below(64));
                address  = (op.width == LDW) ? {address[7:2], 2'b00} :
                           (op.width == LDH) ? {address[7:1], 1'b0} : address;
                run_load(address, op, 1'b0, 0);
            end else begin
                op.width = (i % 3 == 0) ? LDH : LDW;
                address  = 8'(random_below(192));
                if (op.width == LDH) begin
                    address[0] = 1'b1;
                end else if (address[1:0] == 2'b00) begin
                    address[1:0] = 2'(1 + random_below(3));
                end
                run_load(address, op, (random_below(2) == 1), 0);
            end
        end

        // Several stores to one word, then an immediate load of it
        op.width       = LDW;
        op.signed_load = 1'b0;
        for (int b = 0; b < N_BURST; b++) begin
            address   = 8'(random_below(256));
            burst_len = 2 + int'(random_below(3));
            for (int k = 0; k < burst_len; k++) begin
                store_word({address[7:2], 2'(random_below(4))}, random_word());
            end
            run_load({address[7:2], 2'b00}, op, 1'b1, 0);
        end

        // Loads with a stall of 1 to 8 cycles
        for (int i = 0; i < N_STALL; i++) begin
            op.width       = ldu_width_t'(2'(random_below(3)));
            op.signed_load = (random_below(2) == 1);
            address        = 8'(random_below(256));
            address        = {address[7:2], 2'b00};
            run_load(address, op, 1'b1, 1 + int'(random_below(8)));
        end

        // Mixed traffic, mostly privileged, with random stall
        for (int i = 0; i < N_MIXED; i++) begin
            if (random_below(3) == 0) begin
                store_word(8'(random_below(256)), random_word());
            end else begin
                op.width       = ldu_width_t'(2'(random_below(3)));
                op.signed_load = (random_below(2) == 1);
                address        = 8'(random_below(256));
                address        = (op.width == LDW) ? {address[7:2], 2'b00} :
                                 (op.width == LDH) ? {address[7:1], 1'b0} : address;
                run_load(address, op, (random_below(4) != 0), int'(random_below(9)));
            end
        end

        $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : load_subsystem_tb

/* load_subsystem.f */
+incdir+include
hdl/lsu_pkg.sv
hdl/load_unit.sv
hdl/store_buffer.sv
hdl/data_memory.sv
hdl/load_subsystem.sv
bench/load_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the load subsystem testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module load_subsystem_tb \
    -f load_subsystem.f \
    -o load_subsystem_sim \
    && ./obj_dir/load_subsystem_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
